/* rtl/fifo_cfg.svh */
// fifo controller configuration macros
// ram depth, address width and the static almost thresholds

`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// ----------------------------------------
// ram geometry
// ----------------------------------------

// number of ram entries, not a power of two
`define FIFO_DEPTH 12

// ram address width, must cover depth-1
`define FIFO_ADDR_W 4

// ----------------------------------------
// almost thresholds
// ----------------------------------------

// afull set at or above this count
`define FIFO_AFULL_VAL 10

// aempty set at or below this count
`define FIFO_AEMPTY_VAL 2

`endif

/* rtl/fifo_types_pkg.sv */
// fifo controller scalar types
// address and count vectors, fill-state enum

`include "fifo_cfg.svh"

package fifo_types_pkg;

   // ----------------------------------------
   // vectors
   // ----------------------------------------

   // ram address, write or read side
   typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

   // occupancy 0..depth, one extra bit for full
   typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

   // ----------------------------------------
   // fill state
   // ----------------------------------------

   // empty, in between, or full
   typedef enum logic [1:0] {
      FILL_EMPTY   = 2'd0,
      FILL_PARTIAL = 2'd1,
      FILL_FULL    = 2'd2
   } fifo_fill_state_e;

endpackage

/* rtl/fifo_bus_pkg.sv */
// fifo controller grouped signals
// ram port, status flags and one-cycle pulses

package fifo_bus_pkg;

   // ----------------------------------------
   // external ram port
   // ----------------------------------------

   // strobes are high in the cycle of the accepted request
   typedef struct packed {
      // write address and strobe
      fifo_types_pkg::fifo_addr_t waddr;
      logic                       we;
      // read address and strobe
      fifo_types_pkg::fifo_addr_t raddr;
      logic                       re;
   } fifo_mem_port_t;

   // ----------------------------------------
   // status group
   // ----------------------------------------

   // all registered, aligned with count
   typedef struct packed {
      logic                        full;
      logic                        afull;
      logic                        empty;
      logic                        aempty;
      // stored entries
      fifo_types_pkg::fifo_count_t count;
   } fifo_status_t;

   // ----------------------------------------
   // pulse group
   // ----------------------------------------

   // each high for one cycle after the request edge
   typedef struct packed {
      logic wack;
      logic dvld;
      logic overflow;
      logic underflow;
   } fifo_pulse_t;

endpackage

/* rtl/fifo_addr_counter.sv */
// wrapping ram address counter
// shared by the write side and the read side

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_addr_counter (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   // advance by one on the next edge
   input  logic                       step_i,
   output fifo_types_pkg::fifo_addr_t addr_o
);

   // current address
   fifo_types_pkg::fifo_addr_t addr_q;

   // ----------------------------------------
   // counter
   // ----------------------------------------

   // wraps at depth-1, depth need not be a power of two
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         addr_q <= '0;
      end else if (step_i) begin
         if (addr_q == fifo_types_pkg::fifo_addr_t'(`FIFO_DEPTH - 1)) begin
            addr_q <= '0;
         end else begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   assign addr_o = addr_q;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // address stays inside the ram, the spare codes are never used
   a_addr_in_range: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      addr_q < fifo_types_pkg::fifo_addr_t'(`FIFO_DEPTH)
   ) else $error("address counter left the ram range");

endmodule

/* rtl/fifo_occupancy.sv */
// occupancy counter of the fifo
// up on write, down on read, with static almost compares

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_occupancy (
   input  logic                        pos_clk,
   input  logic                        aresetn,
   // accepted write
   input  logic                        inc_i,
   // accepted read
   input  logic                        dec_i,
   output fifo_types_pkg::fifo_count_t count_o,
   output logic                        afull_o,
   output logic                        aempty_o
);

   // registered count and its next value
   fifo_types_pkg::fifo_count_t count_q;
   fifo_types_pkg::fifo_count_t count_nxt;

   // registered almost flags
   logic afull_q;
   logic aempty_q;

   // ----------------------------------------
   // next count
   // ----------------------------------------

   // write and read together cancel out
   always_comb begin
      count_nxt = count_q;
      if (inc_i && !dec_i) begin
         count_nxt = count_q + 1'b1;
      end else if (dec_i && !inc_i) begin
         count_nxt = count_q - 1'b1;
      end
   end

   // ----------------------------------------
   // count and almost flags
   // ----------------------------------------

   // flags come from the next count
   // so they switch on the same edge as the count itself
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_q  <= '0;
         afull_q  <= 1'b0;
         // count 0 is below the aempty threshold
         aempty_q <= 1'b1;
      end else begin
         count_q  <= count_nxt;
         afull_q  <= (count_nxt >= fifo_types_pkg::fifo_count_t'(`FIFO_AFULL_VAL));
         aempty_q <= (count_nxt <= fifo_types_pkg::fifo_count_t'(`FIFO_AEMPTY_VAL));
      end
   end

   assign count_o  = count_q;
   assign afull_o  = afull_q;
   assign aempty_o = aempty_q;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // the fill fsm must hold writes off at full
   a_count_max: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      count_q <= fifo_types_pkg::fifo_count_t'(`FIFO_DEPTH)
   ) else $error("occupancy count above depth");

   // a lone read never reaches an empty fifo
   a_no_dec_at_zero: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      (dec_i && !inc_i) |-> (count_q != '0)
   ) else $error("occupancy decrement at zero");

   // a lone write never reaches a full fifo
   a_no_inc_at_full: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      (inc_i && !dec_i) |-> (count_q != fifo_types_pkg::fifo_count_t'(`FIFO_DEPTH))
   ) else $error("occupancy increment at depth");

endmodule

/* rtl/fifo_fill_fsm.sv */
// fill-state machine of the fifo controller
// accepts or drops requests, decodes full and empty,
// registers the wack, dvld, overflow and underflow pulses

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_fill_fsm (
   input  logic                        pos_clk,
   input  logic                        aresetn,
   // request levels from the environment
   input  logic                        wr_req_i,
   input  logic                        rd_req_i,
   // registered occupancy
   input  fifo_types_pkg::fifo_count_t count_i,
   // combinational acceptance strobes
   output logic                        wr_accept_o,
   output logic                        rd_accept_o,
   output logic                        full_o,
   output logic                        empty_o,
   output fifo_bus_pkg::fifo_pulse_t   pulse_o
);

   // state register and next state
   fifo_types_pkg::fifo_fill_state_e state_q;
   fifo_types_pkg::fifo_fill_state_e state_nxt;

   // acceptance and rejection terms
   logic wr_accept;
   logic rd_accept;
   logic wr_reject;
   logic rd_reject;

   // registered pulse group
   fifo_bus_pkg::fifo_pulse_t pulse_q;

   // ----------------------------------------
   // acceptance
   // ----------------------------------------

   // writes stop at full, reads stop at empty
   assign wr_accept = wr_req_i && (state_q != fifo_types_pkg::FILL_FULL);
   assign rd_accept = rd_req_i && (state_q != fifo_types_pkg::FILL_EMPTY);

   // dropped requests, reported one cycle later
   assign wr_reject = wr_req_i && (state_q == fifo_types_pkg::FILL_FULL);
   assign rd_reject = rd_req_i && (state_q == fifo_types_pkg::FILL_EMPTY);

   assign wr_accept_o = wr_accept;
   assign rd_accept_o = rd_accept;

   // ----------------------------------------
   // next state
   // ----------------------------------------

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         fifo_types_pkg::FILL_EMPTY: begin
            // a read cannot be accepted here, so a write always fills
            if (wr_accept) begin
               state_nxt = fifo_types_pkg::FILL_PARTIAL;
            end
         end
         fifo_types_pkg::FILL_PARTIAL: begin
            // last free slot taken by a lone write
            if (wr_accept && !rd_accept &&
                count_i == fifo_types_pkg::fifo_count_t'(`FIFO_DEPTH - 1)) begin
               state_nxt = fifo_types_pkg::FILL_FULL;
            // last entry drained by a lone read
            end else if (rd_accept && !wr_accept &&
                         count_i == fifo_types_pkg::fifo_count_t'(1)) begin
               state_nxt = fifo_types_pkg::FILL_EMPTY;
            end
         end
         fifo_types_pkg::FILL_FULL: begin
            // the write of a simultaneous pair is dropped
            if (rd_accept) begin
               state_nxt = fifo_types_pkg::FILL_PARTIAL;
            end
         end
         default: begin
            state_nxt = fifo_types_pkg::FILL_EMPTY;
         end
      endcase
   end

   // ----------------------------------------
   // state and pulse registers
   // ----------------------------------------

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= fifo_types_pkg::FILL_EMPTY;
         pulse_q <= '0;
      end else begin
         state_q           <= state_nxt;
         // handshake one cycle after the accepted request
         pulse_q.wack      <= wr_accept;
         pulse_q.dvld      <= rd_accept;
         // errors one cycle after the dropped request
         pulse_q.overflow  <= wr_reject;
         pulse_q.underflow <= rd_reject;
      end
   end

   // flags straight from the state
   assign full_o  = (state_q == fifo_types_pkg::FILL_FULL);
   assign empty_o = (state_q == fifo_types_pkg::FILL_EMPTY);
   assign pulse_o = pulse_q;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // full and empty are exclusive
   a_full_empty_excl: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      !(full_o && empty_o)
   ) else $error("full and empty both high");

   // state and occupancy counter move together
   a_state_matches_count: assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      ((state_q == fifo_types_pkg::FILL_EMPTY) == (count_i == '0)) &&
      ((state_q == fifo_types_pkg::FILL_FULL) ==
       (count_i == fifo_types_pkg::fifo_count_t'(`FIFO_DEPTH)))
   ) else $error("fill state disagrees with occupancy count");

endmodule

/* rtl/fifo_sync_ctrl.sv */
// single-clock fifo controller top
// addresses and strobes for an external dual-port ram, status and pulses

`timescale 1ns/1ps

module fifo_sync_ctrl (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  logic                         wr_req_i,
   input  logic                         rd_req_i,
   output fifo_bus_pkg::fifo_mem_port_t mem_o,
   output fifo_bus_pkg::fifo_status_t   status_o,
   output fifo_bus_pkg::fifo_pulse_t    pulse_o
);

   // acceptance strobes from the fsm
   logic wr_accept;
   logic rd_accept;

   // ram addresses
   fifo_types_pkg::fifo_addr_t waddr;
   fifo_types_pkg::fifo_addr_t raddr;

   // status pieces
   fifo_types_pkg::fifo_count_t count;
   logic                        full;
   logic                        empty;
   logic                        afull;
   logic                        aempty;

   // ----------------------------------------
   // control
   // ----------------------------------------

   fifo_fill_fsm fifo_fill_fsm_inst (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_req_i    (wr_req_i),
      .rd_req_i    (rd_req_i),
      .count_i     (count),
      .wr_accept_o (wr_accept),
      .rd_accept_o (rd_accept),
      .full_o      (full),
      .empty_o     (empty),
      .pulse_o     (pulse_o)
   );

   fifo_occupancy fifo_occupancy_inst (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .inc_i    (wr_accept),
      .dec_i    (rd_accept),
      .count_o  (count),
      .afull_o  (afull),
      .aempty_o (aempty)
   );

   // ----------------------------------------
   // address path
   // ----------------------------------------

   // write side
   fifo_addr_counter wr_addr_counter_inst (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .step_i  (wr_accept),
      .addr_o  (waddr)
   );

   // read side
   fifo_addr_counter rd_addr_counter_inst (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .step_i  (rd_accept),
      .addr_o  (raddr)
   );

   // strobes reach the ram with no latency
   assign mem_o = '{waddr: waddr, we: wr_accept, raddr: raddr, re: rd_accept};

   assign status_o = '{full: full, afull: afull, empty: empty, aempty: aempty, count: count};

endmodule

/* verif/fifo_sync_ctrl_tb.sv */
// testbench of the single-clock fifo controller
// clock, reset, directed and random requests,
// ram and occupancy models, checking assertions

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_sync_ctrl_tb;

   // cycles allowed for a fill or a drain
   localparam int wait_limit = 4 * `FIFO_DEPTH;

   // status right after reset
   localparam fifo_bus_pkg::fifo_status_t reset_status =
      '{full: 1'b0, afull: 1'b0, empty: 1'b1, aempty: 1'b1, count: '0};

   logic                         pos_clk;
   logic                         aresetn;
   logic                         wr_req_i;
   logic                         rd_req_i;
   fifo_bus_pkg::fifo_mem_port_t mem_o;
   fifo_bus_pkg::fifo_status_t   status_o;
   fifo_bus_pkg::fifo_pulse_t    pulse_o;

   // model state
   int                           model_count;
   logic                         wr_ok;
   logic                         rd_ok;
   fifo_types_pkg::fifo_addr_t   exp_waddr;
   fifo_types_pkg::fifo_addr_t   exp_raddr;
   fifo_bus_pkg::fifo_pulse_t    exp_pulse;
   logic [15:0]                  ram [0:`FIFO_DEPTH-1];
   logic [15:0]                  wr_data;
   logic [15:0]                  rd_data_q;
   logic [15:0]                  exp_data;
   int unsigned                  seed_value;

   fifo_sync_ctrl fifo_sync_ctrl_inst (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_req_i (wr_req_i),
      .rd_req_i (rd_req_i),
      .mem_o    (mem_o),
      .status_o (status_o),
      .pulse_o  (pulse_o)
   );

   // 40 ns period
   initial begin
      pos_clk = 1'b0;
      forever #20 pos_clk = ~pos_clk;
   end

   // ----------------------------------------
   // failure reporting
   // ----------------------------------------

   task automatic stop_on_failure(input string reason);
      $display("%s", reason);
      $display("Verification failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string signal_name, input int expected,
                                  input int actual);
      $display("Error at %0t: %s expected %0d actual %0d", $time, signal_name,
               expected, actual);
      stop_on_failure("value mismatch");
   endtask

   // ----------------------------------------
   // models
   // ----------------------------------------

   // next ram address wrapping at depth-1
   function automatic fifo_types_pkg::fifo_addr_t next_addr(input fifo_types_pkg::fifo_addr_t a);
      if (a == `FIFO_DEPTH - 1) begin
         return '0;
      end
      return a + 1'b1;
   endfunction

   // same acceptance rule as the fifo contract
   assign wr_ok = wr_req_i && (model_count != `FIFO_DEPTH);
   assign rd_ok = rd_req_i && (model_count != 0);

   always @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         model_count <= 0;
         exp_waddr   <= '0;
         exp_raddr   <= '0;
         exp_pulse   <= '0;
         wr_data     <= '0;
         exp_data    <= '0;
         rd_data_q   <= '0;
      end else begin
         model_count <= model_count + int'(wr_ok) - int'(rd_ok);
         if (wr_ok) begin
            exp_waddr <= next_addr(exp_waddr);
         end
         if (rd_ok) begin
            exp_raddr <= next_addr(exp_raddr);
         end
         exp_pulse <= '{wack: wr_ok, dvld: rd_ok,
                        overflow: wr_req_i && !wr_ok, underflow: rd_req_i && !rd_ok};
         // external ram written and read through the dut port
         if (mem_o.we) begin
            ram[mem_o.waddr] <= wr_data;
            wr_data          <= wr_data + 1'b1;
         end
         if (mem_o.re) begin
            rd_data_q <= ram[mem_o.raddr];
         end
         // fifo order means the n-th read returns the n-th write
         if (exp_pulse.dvld) begin
            exp_data <= exp_data + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------

   a_reset_status: assert property (@(posedge pos_clk) $rose(aresetn) |->
      status_o == reset_status)
      else report_mismatch("status_o", int'(reset_status), int'($sampled(status_o)));

   a_count: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_o.count == model_count)
      else report_mismatch("status_o.count", $sampled(model_count), $sampled(status_o.count));

   a_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_o.full == (model_count == `FIFO_DEPTH))
      else report_mismatch("status_o.full", $sampled(model_count == `FIFO_DEPTH),
                           $sampled(status_o.full));

   a_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_o.empty == (model_count == 0))
      else report_mismatch("status_o.empty", $sampled(model_count == 0),
                           $sampled(status_o.empty));

   a_afull: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_o.afull == (model_count >= `FIFO_AFULL_VAL))
      else report_mismatch("status_o.afull", $sampled(model_count >= `FIFO_AFULL_VAL),
                           $sampled(status_o.afull));

   a_aempty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_o.aempty == (model_count <= `FIFO_AEMPTY_VAL))
      else report_mismatch("status_o.aempty", $sampled(model_count <= `FIFO_AEMPTY_VAL),
                           $sampled(status_o.aempty));

   // strobes against the model acceptance, so never high while full or empty
   a_we: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_o.we == wr_ok)
      else report_mismatch("mem_o.we", $sampled(wr_ok), $sampled(mem_o.we));

   a_re: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_o.re == rd_ok)
      else report_mismatch("mem_o.re", $sampled(rd_ok), $sampled(mem_o.re));

   a_waddr: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_o.waddr == exp_waddr)
      else report_mismatch("mem_o.waddr", $sampled(exp_waddr), $sampled(mem_o.waddr));

   a_raddr: assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_o.raddr == exp_raddr)
      else report_mismatch("mem_o.raddr", $sampled(exp_raddr), $sampled(mem_o.raddr));

   a_read_data: assert property (@(posedge pos_clk) disable iff (!aresetn)
      exp_pulse.dvld |-> rd_data_q == exp_data)
      else report_mismatch("read data", $sampled(exp_data), $sampled(rd_data_q));

   // one-cycle pulses
   a_wack: assert property (@(posedge pos_clk) disable iff (!aresetn)
      pulse_o.wack == exp_pulse.wack)
      else report_mismatch("pulse_o.wack", $sampled(exp_pulse.wack), $sampled(pulse_o.wack));

   a_dvld: assert property (@(posedge pos_clk) disable iff (!aresetn)
      pulse_o.dvld == exp_pulse.dvld)
      else report_mismatch("pulse_o.dvld", $sampled(exp_pulse.dvld), $sampled(pulse_o.dvld));

   a_overflow: assert property (@(posedge pos_clk) disable iff (!aresetn)
      pulse_o.overflow == exp_pulse.overflow)
      else report_mismatch("pulse_o.overflow", $sampled(exp_pulse.overflow),
                           $sampled(pulse_o.overflow));

   a_underflow: assert property (@(posedge pos_clk) disable iff (!aresetn)
      pulse_o.underflow == exp_pulse.underflow)
      else report_mismatch("pulse_o.underflow", $sampled(exp_pulse.underflow),
                           $sampled(pulse_o.underflow));

   // ----------------------------------------
   // stimulus
   // ----------------------------------------

   // hold the request levels for a number of cycles
   task automatic hold_requests(input logic wr, input logic rd, input int cycles);
      repeat (cycles) begin
         @(negedge pos_clk);
         wr_req_i = wr;
         rd_req_i = rd;
      end
   endtask

   // write burst that ends once full shows
   task automatic write_until_full;
      int cycles;
      cycles = 0;
      @(negedge pos_clk);
      wr_req_i = 1'b1;
      rd_req_i = 1'b0;
      while (!status_o.full) begin
         @(negedge pos_clk);
         cycles++;
         if (cycles > wait_limit) begin
            stop_on_failure("timeout while waiting for the fifo to become full");
         end
      end
   endtask

   // read burst that ends once empty shows
   task automatic read_until_empty;
      int cycles;
      cycles = 0;
      @(negedge pos_clk);
      wr_req_i = 1'b0;
      rd_req_i = 1'b1;
      while (!status_o.empty) begin
         @(negedge pos_clk);
         cycles++;
         if (cycles > wait_limit) begin
            stop_on_failure("timeout while waiting for the fifo to become empty");
         end
      end
   endtask

   // biased phases of 50 cycles so that full and empty are both reached
   task automatic random_requests(input int n_cycles);
      bit write_heavy;
      for (int i = 0; i < n_cycles; i++) begin
         @(negedge pos_clk);
         write_heavy = ((i / 50) % 2) == 0;
         if (write_heavy) begin
            wr_req_i = ($urandom % 4) != 0;
            rd_req_i = ($urandom % 4) == 0;
         end else begin
            wr_req_i = ($urandom % 4) == 0;
            rd_req_i = ($urandom % 4) != 0;
         end
      end
   endtask

   initial begin
      aresetn    = 1'b0;
      wr_req_i   = 1'b0;
      rd_req_i   = 1'b0;
      seed_value = $urandom(32'hbb8f);
      repeat (5) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn = 1'b1;

      write_until_full();
      // writes against a full fifo
      hold_requests(1'b1, 1'b0, 3);
      read_until_empty();
      // reads against an empty fifo
      hold_requests(1'b0, 1'b1, 3);
      random_requests(400);
      hold_requests(1'b0, 1'b0, 3);

      $display("Verification passed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+rtl
rtl/fifo_types_pkg.sv
rtl/fifo_bus_pkg.sv
rtl/fifo_addr_counter.sv
rtl/fifo_occupancy.sv
rtl/fifo_fill_fsm.sv
rtl/fifo_sync_ctrl.sv
verif/fifo_sync_ctrl_tb.sv

/* Bender.yml */
package:
  name: fifo_sync_ctrl

sources:
  # controller rtl, packages first
  - include_dirs:
      - rtl
    files:
      - rtl/fifo_types_pkg.sv
      - rtl/fifo_bus_pkg.sv
      - rtl/fifo_addr_counter.sv
      - rtl/fifo_occupancy.sv
      - rtl/fifo_fill_fsm.sv
      - rtl/fifo_sync_ctrl.sv

  # testbench
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/fifo_sync_ctrl_tb.sv
